// ==== regfile_sub.f ====
logic/regfile_pkg.sv
logic/reg_bank.sv
logic/read_select.sv
logic/regfile_top.sv
verif/regfile_assertions.sv
verif/tb_regfile.sv

// ==== verif/tb_regfile.sv ====
/*
  Register file testbench
  Directed tests on the top level against a 64-entry reference model,
  followed by a short run of seeded random traffic
*/
module tb_regfile;

  timeunit 1ns;
  timeprecision 1ps;

  import regfile_pkg::*;

  localparam int       RESET_TIMEOUT = 20;
  localparam int       RANDOM_CYCLES = 40;
  localparam wr_port_t IDLE          = '0;

  logic      clk_int;
  logic      rst_n;
  wr_port_t  wr_a;
  wr_port_t  wr_b;
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_addr_t raddr_c;
  reg_word_t rdata_a;
  reg_word_t rdata_b;
  reg_word_t rdata_c;

  // Reference model indexed by the full 6-bit address
  reg_word_t model [2**REG_ADDR_W];
  int        seed;

  regfile_top #(
    .FP_EN (1)
  ) regfile_top_i (
    .clk_int   (clk_int),
    .rst_n     (rst_n),
    .wr_a_i    (wr_a),
    .wr_b_i    (wr_b),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (rdata_c)
  );

  // 100 ns clock
  initial
  begin
    clk_int = 1'b0;
    forever #50 clk_int = ~clk_int;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic reg_addr_t make_addr(input logic fp_sel, input int idx);
    reg_addr_t a;
    a.fp_sel = fp_sel;
    a.index  = idx[BANK_ADDR_W-1:0];
    return a;
  endfunction

  function automatic wr_port_t make_port(input reg_addr_t addr, input reg_word_t data);
    wr_port_t p;
    p.we   = 1'b1;
    p.addr = addr;
    p.data = data;
    return p;
  endfunction

  // x0 ignores writes and port B lands last so it wins the collision
  function automatic void commit_writes(input wr_port_t pa, input wr_port_t pb);
    if (pa.we && (pa.addr != '0))
      model[pa.addr] = pa.data;
    if (pb.we && (pb.addr != '0))
      model[pb.addr] = pb.data;
  endfunction

  task automatic check_word(input string test_name, input string what,
                            input reg_word_t expected, input reg_word_t actual);
    if (actual !== expected)
    begin
      $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Read data mismatch");
    end
  endtask

  task automatic check_reads(input string test_name);
    check_word(test_name, "read port a", model[raddr_a], rdata_a);
    check_word(test_name, "read port b", model[raddr_b], rdata_b);
    check_word(test_name, "read port c", model[raddr_c], rdata_c);
  endtask

  // Drive one cycle and check reads mid-cycle before its writes commit
  task automatic run_cycle(input string test_name, input wr_port_t pa, input wr_port_t pb,
                           input reg_addr_t ra, input reg_addr_t rb, input reg_addr_t rc);
    @(posedge clk_int);
    wr_a    <= pa;
    wr_b    <= pb;
    raddr_a <= ra;
    raddr_b <= rb;
    raddr_c <= rc;
    @(negedge clk_int);
    check_reads(test_name);
    commit_writes(pa, pb);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1)
    begin
      @(posedge clk_int);
      cycles++;
      if (cycles > RESET_TIMEOUT)
      begin
        $display("Simulation FAILED");
        $fatal(1, "Reset was not released in time");
      end
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state();
    reg_addr_t a;
    for (int i = 0; i < 2**REG_ADDR_W; i++)
    begin
      a = i[REG_ADDR_W-1:0];
      run_cycle("reset_state", IDLE, IDLE, a, a, a);
      check_word("reset_state", "after reset", '0, rdata_a);
    end
  endtask

  task automatic test_int_writes();
    reg_addr_t x7;
    reg_addr_t x12;
    x7  = make_addr(1'b0, 7);
    x12 = make_addr(1'b0, 12);
    // Old value still seen during the write cycle
    run_cycle("int_writes", make_port(x7, 32'h1234_5678), IDLE, x7, x7, x7);
    run_cycle("int_writes", IDLE, IDLE, x7, x7, x7);
    run_cycle("int_writes", IDLE, make_port(x12, 32'hcafe_f00d), x12, x12, x12);
    run_cycle("int_writes", IDLE, IDLE, x12, x12, x12);
    check_word("int_writes", "x12 value", 32'hcafe_f00d, rdata_a);
  endtask

  task automatic test_zero_reg();
    reg_addr_t x0;
    x0 = make_addr(1'b0, 0);
    run_cycle("zero_reg", make_port(x0, 32'hdead_beef), IDLE, x0, x0, x0);
    run_cycle("zero_reg", IDLE, make_port(x0, 32'hffff_ffff), x0, x0, x0);
    run_cycle("zero_reg", IDLE, IDLE, x0, x0, x0);
    check_word("zero_reg", "x0 after writes", '0, rdata_b);
  endtask

  task automatic test_fp_vs_int();
    reg_addr_t f0;
    reg_addr_t f5;
    reg_addr_t x0;
    reg_addr_t x5;
    f0 = make_addr(1'b1, 0);
    f5 = make_addr(1'b1, 5);
    x0 = make_addr(1'b0, 0);
    x5 = make_addr(1'b0, 5);
    run_cycle("fp_vs_int", make_port(f0, 32'h3f80_0000), make_port(x5, 32'h0000_0055),
              f0, x5, x0);
    run_cycle("fp_vs_int", IDLE, IDLE, f0, x5, x0);
    // FP f0 holds data while x0 stays zero
    check_word("fp_vs_int", "f0 value", 32'h3f80_0000, rdata_a);
    run_cycle("fp_vs_int", IDLE, IDLE, f5, x0, f0);
  endtask

  task automatic test_collision();
    reg_addr_t x9;
    reg_addr_t x10;
    reg_addr_t f10;
    x9  = make_addr(1'b0, 9);
    x10 = make_addr(1'b0, 10);
    f10 = make_addr(1'b1, 10);
    run_cycle("collision", make_port(x9, 32'haaaa_aaaa), make_port(x9, 32'hbbbb_bbbb),
              x9, x9, x9);
    run_cycle("collision", IDLE, IDLE, x9, x9, x9);
    check_word("collision", "port b priority", 32'hbbbb_bbbb, rdata_c);
    // Both writes land on separate targets
    run_cycle("collision", make_port(x10, 32'h0101_0101), make_port(f10, 32'h0202_0202),
              x10, f10, x9);
    run_cycle("collision", IDLE, IDLE, x10, f10, x9);
  endtask

  task automatic test_random();
    wr_port_t  pa;
    wr_port_t  pb;
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t rc;
    logic [31:0] r;
    pa = IDLE;
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      // Port a rereads the previous port A target
      ra = pa.addr;
      r  = $random(seed);
      rb = r[REG_ADDR_W-1:0];
      rc = r[REG_ADDR_W+7:8];
      r  = $random(seed);
      pa.we   = r[0];
      pb.we   = r[1];
      pa.addr = r[REG_ADDR_W+7:8];
      pb.addr = r[REG_ADDR_W+15:16];
      pa.data = $random(seed);
      pb.data = $random(seed);
      run_cycle("random", pa, pb, ra, rb, rc);
    end
    run_cycle("random", IDLE, IDLE, pa.addr, pb.addr, rc);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial
  begin
    seed    = 32'h6dfe542c;
    rst_n   = 1'b0;
    wr_a    = IDLE;
    wr_b    = IDLE;
    raddr_a = '0;
    raddr_b = '0;
    raddr_c = '0;
    for (int i = 0; i < 2**REG_ADDR_W; i++)
      model[i] = '0;

    repeat (3) @(posedge clk_int);
    rst_n <= 1'b1;
    wait_reset_release();

    test_reset_state();
    test_int_writes();
    test_zero_reg();
    test_fp_vs_int();
    test_collision();
    test_random();

    // Let the last assertions sample
    run_cycle("drain", IDLE, IDLE, '0, '0, '0);
    @(posedge clk_int);

    if (regfile_top_i.regfile_assertions_i.fail_count != 0)
    begin
      $display("Simulation FAILED");
      $fatal(1, "Bound assertions reported failures");
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== verif/regfile_assertions.sv ====
/*
  Register file assertions
  Bound to the top level to check the hardwired x0 on every read port
  and that a lone write shows up on a read of the same register next cycle
*/
module regfile_assertions (
  input logic                   clk_int,
  input logic                   rst_n,
  input regfile_pkg::wr_port_t  wr_a_i,
  input regfile_pkg::wr_port_t  wr_b_i,
  input regfile_pkg::reg_addr_t raddr_a_i,
  input regfile_pkg::reg_addr_t raddr_b_i,
  input regfile_pkg::reg_addr_t raddr_c_i,
  input regfile_pkg::reg_word_t rdata_a_o,
  input regfile_pkg::reg_word_t rdata_b_o,
  input regfile_pkg::reg_word_t rdata_c_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import regfile_pkg::*;

  // Count of failed assertions
  int unsigned fail_count = 0;

  // --------------------
  // Integer x0
  // --------------------

  x0_port_a: assert property (@(posedge clk_int) (raddr_a_i == '0) |-> (rdata_a_o == '0))
    else
    begin
      fail_count++;
      $error("Read port a returned nonzero data for x0");
    end

  x0_port_b: assert property (@(posedge clk_int) (raddr_b_i == '0) |-> (rdata_b_o == '0))
    else
    begin
      fail_count++;
      $error("Read port b returned nonzero data for x0");
    end

  x0_port_c: assert property (@(posedge clk_int) (raddr_c_i == '0) |-> (rdata_c_o == '0))
    else
    begin
      fail_count++;
      $error("Read port c returned nonzero data for x0");
    end

  // --------------------
  // Write then read
  // --------------------

  // Lone port A write shows up on read port a one cycle later
  wr_a_visible: assert property (@(posedge clk_int) disable iff (!rst_n)
    (wr_a_i.we && !wr_b_i.we && (wr_a_i.addr != '0))
    |=> ((raddr_a_i != $past(wr_a_i.addr)) || (rdata_a_o == $past(wr_a_i.data))))
    else
    begin
      fail_count++;
      $error("Port A write not visible on read port a");
    end

  // Lone port B write shows up on read port b one cycle later
  wr_b_visible: assert property (@(posedge clk_int) disable iff (!rst_n)
    (wr_b_i.we && !wr_a_i.we && (wr_b_i.addr != '0))
    |=> ((raddr_b_i != $past(wr_b_i.addr)) || (rdata_b_o == $past(wr_b_i.data))))
    else
    begin
      fail_count++;
      $error("Port B write not visible on read port b");
    end

endmodule

bind regfile_top regfile_assertions regfile_assertions_i (.*);

// ==== logic/regfile_top.sv ====
/*
  Register file top
  Integer bank with hardwired x0, optional FP bank and the read selector.
  Write ports are split per bank by the bank-select address bit
*/
module regfile_top #(
  parameter int FP_EN = 1
) (
  input  logic                   clk_int,
  input  logic                   rst_n,

  // Write ports
  input  regfile_pkg::wr_port_t  wr_a_i,
  input  regfile_pkg::wr_port_t  wr_b_i,

  // Read addresses
  input  regfile_pkg::reg_addr_t raddr_a_i,
  input  regfile_pkg::reg_addr_t raddr_b_i,
  input  regfile_pkg::reg_addr_t raddr_c_i,

  // Read data
  output regfile_pkg::reg_word_t rdata_a_o,
  output regfile_pkg::reg_word_t rdata_b_o,
  output regfile_pkg::reg_word_t rdata_c_o
);

  import regfile_pkg::*;

  localparam logic FP_ON = (FP_EN != 0);

  // Integer bank write ports
  bank_wr_t int_wr_a;
  bank_wr_t int_wr_b;

  // Bank read words
  reg_word_t int_rdata_a;
  reg_word_t int_rdata_b;
  reg_word_t int_rdata_c;
  reg_word_t fp_rdata_a;
  reg_word_t fp_rdata_b;
  reg_word_t fp_rdata_c;

  // Narrow a write port to a bank, enable only on a bank hit
  function automatic bank_wr_t to_bank(input wr_port_t port, input logic hit);
    bank_wr_t bw;
    bw.we    = port.we & hit;
    bw.index = port.addr.index;
    bw.data  = port.data;
    return bw;
  endfunction

  // --------------------
  // Integer bank
  // --------------------

  // Integer side takes everything not steered to FP
  assign int_wr_a = to_bank(wr_a_i, ~(FP_ON & wr_a_i.addr.fp_sel));
  assign int_wr_b = to_bank(wr_b_i, ~(FP_ON & wr_b_i.addr.fp_sel));

  reg_bank #(
    .ZERO_REG (1)
  ) int_bank (
    .clk_int   (clk_int),
    .rst_n     (rst_n),
    .wr_a_i    (int_wr_a),
    .wr_b_i    (int_wr_b),
    .raddr_a_i (raddr_a_i.index),
    .raddr_b_i (raddr_b_i.index),
    .raddr_c_i (raddr_c_i.index),
    .rdata_a_o (int_rdata_a),
    .rdata_b_o (int_rdata_b),
    .rdata_c_o (int_rdata_c)
  );

  // --------------------
  // FP bank
  // --------------------

  if (FP_EN != 0)
  begin : gen_fp
    bank_wr_t fp_wr_a;
    bank_wr_t fp_wr_b;

    assign fp_wr_a = to_bank(wr_a_i, wr_a_i.addr.fp_sel);
    assign fp_wr_b = to_bank(wr_b_i, wr_b_i.addr.fp_sel);

    // All 32 FP words are writable
    reg_bank #(
      .ZERO_REG (0)
    ) fp_bank (
      .clk_int   (clk_int),
      .rst_n     (rst_n),
      .wr_a_i    (fp_wr_a),
      .wr_b_i    (fp_wr_b),
      .raddr_a_i (raddr_a_i.index),
      .raddr_b_i (raddr_b_i.index),
      .raddr_c_i (raddr_c_i.index),
      .rdata_a_o (fp_rdata_a),
      .rdata_b_o (fp_rdata_b),
      .rdata_c_o (fp_rdata_c)
    );
  end
  else
  begin : gen_no_fp
    assign fp_rdata_a = '0;
    assign fp_rdata_b = '0;
    assign fp_rdata_c = '0;
  end

  // --------------------
  // Read selection
  // --------------------

  read_select #(
    .FP_EN (FP_EN)
  ) read_select_i (
    .raddr_a_i     (raddr_a_i),
    .raddr_b_i     (raddr_b_i),
    .raddr_c_i     (raddr_c_i),
    .int_rdata_a_i (int_rdata_a),
    .int_rdata_b_i (int_rdata_b),
    .int_rdata_c_i (int_rdata_c),
    .fp_rdata_a_i  (fp_rdata_a),
    .fp_rdata_b_i  (fp_rdata_b),
    .fp_rdata_c_i  (fp_rdata_c),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o),
    .rdata_c_o     (rdata_c_o)
  );

endmodule

// ==== logic/read_select.sv ====
/*
  Read selector
  Picks the integer or FP bank word for each of the three read ports
  from the bank-select bit of the read address
*/
module read_select #(
  parameter int FP_EN = 1
) (
  // Full read addresses
  input  regfile_pkg::reg_addr_t raddr_a_i,
  input  regfile_pkg::reg_addr_t raddr_b_i,
  input  regfile_pkg::reg_addr_t raddr_c_i,

  // Integer bank words
  input  regfile_pkg::reg_word_t int_rdata_a_i,
  input  regfile_pkg::reg_word_t int_rdata_b_i,
  input  regfile_pkg::reg_word_t int_rdata_c_i,

  // FP bank words
  input  regfile_pkg::reg_word_t fp_rdata_a_i,
  input  regfile_pkg::reg_word_t fp_rdata_b_i,
  input  regfile_pkg::reg_word_t fp_rdata_c_i,

  // Selected read data
  output regfile_pkg::reg_word_t rdata_a_o,
  output regfile_pkg::reg_word_t rdata_b_o,
  output regfile_pkg::reg_word_t rdata_c_o
);

  import regfile_pkg::*;

  // FP bank only reachable when present
  localparam logic FP_ON = (FP_EN != 0);

  // Per-port bank choice
  logic use_fp_a;
  logic use_fp_b;
  logic use_fp_c;

  // --------------------
  // Bank choice
  // --------------------

  // Without the FP bank the select bit is ignored
  assign use_fp_a = FP_ON & raddr_a_i.fp_sel;
  assign use_fp_b = FP_ON & raddr_b_i.fp_sel;
  assign use_fp_c = FP_ON & raddr_c_i.fp_sel;

  // --------------------
  // Data muxes
  // --------------------

  function automatic reg_word_t pick(
    input logic      use_fp,
    input reg_word_t int_word,
    input reg_word_t fp_word
  );
    reg_word_t word;
    if (use_fp)
      word = fp_word;
    else
      word = int_word;
    return word;
  endfunction

  // Port A
  assign rdata_a_o = pick(use_fp_a, int_rdata_a_i, fp_rdata_a_i);

  // Port B
  assign rdata_b_o = pick(use_fp_b, int_rdata_b_i, fp_rdata_b_i);

  // Port C
  assign rdata_c_o = pick(use_fp_c, int_rdata_c_i, fp_rdata_c_i);

endmodule

// ==== logic/reg_bank.sv ====
/*
  Register bank
  32 flip-flop words with two write ports and three combinational reads.
  Port B wins a same-word collision and word zero can be hardwired to zero
*/
module reg_bank #(
  parameter int ZERO_REG = 0
) (
  input  logic                                clk_int,
  input  logic                                rst_n,

  // Write ports, already routed to this bank
  input  regfile_pkg::bank_wr_t               wr_a_i,
  input  regfile_pkg::bank_wr_t               wr_b_i,

  // Read indices
  input  logic [regfile_pkg::BANK_ADDR_W-1:0] raddr_a_i,
  input  logic [regfile_pkg::BANK_ADDR_W-1:0] raddr_b_i,
  input  logic [regfile_pkg::BANK_ADDR_W-1:0] raddr_c_i,

  // Read data
  output regfile_pkg::reg_word_t              rdata_a_o,
  output regfile_pkg::reg_word_t              rdata_b_o,
  output regfile_pkg::reg_word_t              rdata_c_o
);

  import regfile_pkg::*;

  localparam int NUM_WORDS = 2**BANK_ADDR_W;

  // Storage
  reg_word_t mem [NUM_WORDS];

  // One-hot word enables per write port
  logic [NUM_WORDS-1:0] we_onehot_a;
  logic [NUM_WORDS-1:0] we_onehot_b;

  // --------------------
  // Write decode
  // --------------------

  always_comb
  begin : write_decode
    we_onehot_a = '0;
    we_onehot_b = '0;
    if (wr_a_i.we)
    begin
      we_onehot_a[wr_a_i.index] = 1'b1;
    end
    if (wr_b_i.we)
    begin
      we_onehot_b[wr_b_i.index] = 1'b1;
    end
    // Hardwired zero word takes no writes
    if (ZERO_REG != 0)
    begin
      we_onehot_a[0] = 1'b0;
      we_onehot_b[0] = 1'b0;
    end
  end

  // --------------------
  // Word storage
  // --------------------

  always_ff @(posedge clk_int or negedge rst_n)
  begin : word_write
    if (!rst_n)
    begin
      for (int w = 0; w < NUM_WORDS; w++)
      begin
        mem[w] <= '0;
      end
    end
    else
    begin
      for (int w = 0; w < NUM_WORDS; w++)
      begin
        // B checked first, so it wins a collision
        if (we_onehot_b[w])
          mem[w] <= wr_b_i.data;
        else if (we_onehot_a[w])
          mem[w] <= wr_a_i.data;
      end
    end
  end

  // --------------------
  // Read ports
  // --------------------

  // Array lookup with the hardwired word forced to zero
  function automatic reg_word_t read_word(input logic [BANK_ADDR_W-1:0] idx);
    reg_word_t word;
    word = mem[idx];
    if ((ZERO_REG != 0) && (idx == '0))
      word = '0;
    return word;
  endfunction

  // Re-evaluated on address changes and on storage updates
  always_comb
  begin : read_ports
    rdata_a_o = read_word(raddr_a_i);
    rdata_b_o = read_word(raddr_b_i);
    rdata_c_o = read_word(raddr_c_i);
  end

endmodule

// ==== logic/regfile_pkg.sv ====
/*
  Register file package
  Word and address widths, the register address layout and the
  write-port structs shared by the banks, the read selector and the top
*/
package regfile_pkg;

  // --------------------
  // Widths
  // --------------------

  // Data word width
  parameter int XLEN = 32;

  // Full register address, top bit picks the FP bank
  parameter int REG_ADDR_W = 6;

  // Index inside one bank
  parameter int BANK_ADDR_W = REG_ADDR_W - 1;

  // --------------------
  // Types
  // --------------------

  typedef logic [XLEN-1:0] reg_word_t;

  // Bank select on top, register index below
  typedef struct packed {
    logic                   fp_sel;
    logic [BANK_ADDR_W-1:0] index;
  } reg_addr_t;

  // Write port as driven from outside, 39 bits
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_word_t data;
  } wr_port_t;

  // Write port after bank routing, 38 bits
  typedef struct packed {
    logic                   we;
    logic [BANK_ADDR_W-1:0] index;
    reg_word_t              data;
  } bank_wr_t;

endpackage
